//--- rtl/ctrl_pkg.sv
/* Control domain shared definitions
   Bus and register widths, thread engine address map, and the structs
   that carry bus, launch and allocation data between the blocks */
package ctrl_pkg;

    // ####################
    // Widths and constants
    // ####################

    localparam int unsigned CTRL_WIDTH      = 32;
    localparam int unsigned ADDR_WIDTH      = 16;
    localparam int unsigned PC_WIDTH        = 16;
    localparam int unsigned TBLOCK_IDX_BITS = 8;
    localparam int unsigned TGROUP_ID_BITS  = 8;
    // One extra bit so a full group of blocks fits
    localparam int unsigned NUM_BLOCKS_BITS = TBLOCK_IDX_BITS + 1;
    localparam int unsigned STRB_WIDTH      = CTRL_WIDTH / 8;

    // Thread engine window, top 256 bytes of the map
    localparam logic [ADDR_WIDTH-1:0] TE_BASE      = 16'hFF00;
    // Read data of the error responder
    localparam logic [CTRL_WIDTH-1:0] ERR_RSP_DATA = 32'hBADCAB1E;

    // ####################
    // Enums
    // ####################

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // Word offsets inside the thread engine window
    typedef enum logic [7:0] {
        REG_PC         = 8'h00,
        REG_DP_ADDR    = 8'h04,
        REG_NUM_BLOCKS = 8'h08,
        REG_CTRL       = 8'h0C,
        REG_STATUS     = 8'h10,
        REG_TGROUP     = 8'h14
    } te_reg_e;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESP
    } bus_state_e;

    // ####################
    // Structs
    // ####################

    // Host to subordinate, grouped per AXI channel
    typedef struct packed {
        logic                  awvalid;
        logic [ADDR_WIDTH-1:0] awaddr;
        logic                  wvalid;
        logic [CTRL_WIDTH-1:0] wdata;
        logic [STRB_WIDTH-1:0] wstrb;
        logic                  bready;
        logic                  arvalid;
        logic [ADDR_WIDTH-1:0] araddr;
        logic                  rready;
    } axil_req_t;

    // Subordinate to host
    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic                  bvalid;
        axil_resp_e            bresp;
        logic                  arready;
        logic                  rvalid;
        logic [CTRL_WIDTH-1:0] rdata;
        axil_resp_e            rresp;
    } axil_rsp_t;

    // Single register access into the thread engine
    typedef struct packed {
        logic                  valid;
        logic                  we;
        te_reg_e               offset;
        logic [CTRL_WIDTH-1:0] wdata;
        logic [STRB_WIDTH-1:0] wstrb;
    } reg_access_t;

    typedef struct packed {
        logic                       valid;
        logic [PC_WIDTH-1:0]        pc;
        logic [CTRL_WIDTH-1:0]      dp_addr;
        logic [NUM_BLOCKS_BITS-1:0] num_blocks;
        logic [TGROUP_ID_BITS-1:0]  tgroup_id;
    } launch_cmd_t;

    // One block handed to the compute clusters
    typedef struct packed {
        logic [PC_WIDTH-1:0]        pc;
        logic [CTRL_WIDTH-1:0]      dp_addr;
        logic [TBLOCK_IDX_BITS-1:0] tblock_idx;
        logic [TGROUP_ID_BITS-1:0]  tgroup_id;
    } alloc_t;

    typedef struct packed {
        logic                       busy;
        logic [NUM_BLOCKS_BITS-1:0] done_count;
    } te_status_t;

endpackage

//--- rtl/axil_bus_ctrl.sv
/* Bus control unit
   AXI4-Lite subordinate with one transaction in flight; decodes the address
   to the thread engine window or answers as the error responder */
`timescale 1ns/1ps

module axil_bus_ctrl (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  ctrl_pkg::axil_req_t             axil_req_i,
    output ctrl_pkg::axil_rsp_t             axil_rsp_o,
    output ctrl_pkg::reg_access_t           reg_access_o,
    input  logic [ctrl_pkg::CTRL_WIDTH-1:0] reg_rdata_i
);
    import ctrl_pkg::*;

    bus_state_e            state_q;
    bus_state_e            state_d;

    // Captured request
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [CTRL_WIDTH-1:0] wdata_q;
    logic [STRB_WIDTH-1:0] wstrb_q;
    logic                  we_q;

    // Registered response
    logic [CTRL_WIDTH-1:0] rdata_q;
    axil_resp_e            resp_q;

    logic                  wr_hs;
    logic                  rd_hs;
    logic                  in_window;
    logic                  rsp_done;

    // ####################
    // Handshakes
    // ####################

    // AW and W taken together
    assign wr_hs = (state_q == IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
    // Read only when no write is waiting
    assign rd_hs = (state_q == IDLE) && axil_req_i.arvalid
                   && !(axil_req_i.awvalid && axil_req_i.wvalid);

    assign rsp_done = (state_q == RESP)
                      && (we_q ? axil_req_i.bready : axil_req_i.rready);

    // Top 256 bytes belong to the thread engine
    assign in_window = (addr_q >= TE_BASE);

    // ####################
    // State machine
    // ####################

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (wr_hs || rd_hs) begin
                    state_d = ACCESS;
                end
            end
            // Single decode cycle
            ACCESS: state_d = RESP;
            RESP: begin
                if (rsp_done) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request capture and response registers
    always_ff @(posedge clk_i) begin
        if (wr_hs) begin
            addr_q  <= axil_req_i.awaddr;
            wdata_q <= axil_req_i.wdata;
            wstrb_q <= axil_req_i.wstrb;
            we_q    <= 1'b1;
        end else if (rd_hs) begin
            addr_q  <= axil_req_i.araddr;
            we_q    <= 1'b0;
        end
        if (state_q == ACCESS) begin
            if (in_window) begin
                resp_q  <= OKAY;
                rdata_q <= reg_rdata_i;
            end else begin
                // Error responder
                resp_q  <= SLVERR;
                rdata_q <= ERR_RSP_DATA;
            end
        end
    end

    // Register access only for window addresses
    always_comb begin
        reg_access_o.valid  = (state_q == ACCESS) && in_window;
        reg_access_o.we     = we_q;
        reg_access_o.offset = te_reg_e'(addr_q[7:0]);
        reg_access_o.wdata  = wdata_q;
        reg_access_o.wstrb  = wstrb_q;
    end

    always_comb begin
        axil_rsp_o.awready = wr_hs;
        axil_rsp_o.wready  = wr_hs;
        axil_rsp_o.arready = rd_hs;
        // Valid held until the host accepts
        axil_rsp_o.bvalid  = (state_q == RESP) && we_q;
        axil_rsp_o.bresp   = resp_q;
        axil_rsp_o.rvalid  = (state_q == RESP) && !we_q;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = resp_q;
    end

endmodule

//--- rtl/te_reg_file.sv
/* Thread engine register file
   Launch configuration and status registers, launch strobe and cache flush */
`timescale 1ns/1ps

module te_reg_file #(
    parameter int unsigned NUM_BLOCKS_MAX = 256
) (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  ctrl_pkg::reg_access_t           reg_access_i,
    output logic [ctrl_pkg::CTRL_WIDTH-1:0] reg_rdata_o,
    input  ctrl_pkg::te_status_t            status_i,
    output ctrl_pkg::launch_cmd_t           launch_o,
    output logic                            flush_ic_o
);
    import ctrl_pkg::*;

    logic [PC_WIDTH-1:0]        pc_q;
    logic [CTRL_WIDTH-1:0]      dp_addr_q;
    logic [NUM_BLOCKS_BITS-1:0] num_blocks_q;
    logic                       launch_q;
    logic                       flush_q;
    // Group id tracking, advanced on each accepted launch
    logic                       busy_q;
    logic [TGROUP_ID_BITS-1:0]  next_tgroup_q;
    logic [TGROUP_ID_BITS-1:0]  last_tgroup_q;

    logic                       wr;
    logic [CTRL_WIDTH-1:0]      num_merged;

    // Byte lanes with strobe set take the new data
    function automatic logic [CTRL_WIDTH-1:0] merge_strb(
        input logic [CTRL_WIDTH-1:0] old_val,
        input logic [CTRL_WIDTH-1:0] new_val,
        input logic [STRB_WIDTH-1:0] strb
    );
        logic [CTRL_WIDTH-1:0] res;
        res = old_val;
        for (int i = 0; i < STRB_WIDTH; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign wr = reg_access_i.valid && reg_access_i.we;
    assign num_merged = merge_strb(CTRL_WIDTH'(num_blocks_q), reg_access_i.wdata,
                                   reg_access_i.wstrb);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q          <= '0;
            dp_addr_q     <= '0;
            num_blocks_q  <= '0;
            launch_q      <= 1'b0;
            flush_q       <= 1'b0;
            busy_q        <= 1'b0;
            next_tgroup_q <= '0;
            last_tgroup_q <= '0;
        end else begin
            // Pulses last one cycle
            launch_q <= 1'b0;
            flush_q  <= 1'b0;
            busy_q   <= status_i.busy;
            // Rising busy marks an accepted launch
            if (status_i.busy && !busy_q) begin
                last_tgroup_q <= next_tgroup_q;
                next_tgroup_q <= next_tgroup_q + 1'b1;
            end
            if (wr) begin
                case (reg_access_i.offset)
                    REG_PC: begin
                        pc_q <= PC_WIDTH'(merge_strb(CTRL_WIDTH'(pc_q), reg_access_i.wdata,
                                                     reg_access_i.wstrb));
                    end
                    REG_DP_ADDR: begin
                        dp_addr_q <= merge_strb(dp_addr_q, reg_access_i.wdata,
                                                reg_access_i.wstrb);
                    end
                    REG_NUM_BLOCKS: begin
                        // Clamp to the supported maximum
                        if (num_merged > NUM_BLOCKS_MAX) begin
                            num_blocks_q <= NUM_BLOCKS_BITS'(NUM_BLOCKS_MAX);
                        end else begin
                            num_blocks_q <= num_merged[NUM_BLOCKS_BITS-1:0];
                        end
                    end
                    REG_CTRL: begin
                        // Start in bit 0, flush in bit 1, low byte lane
                        launch_q <= reg_access_i.wstrb[0] && reg_access_i.wdata[0];
                        flush_q  <= reg_access_i.wstrb[0] && reg_access_i.wdata[1];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Reads, unknown offsets give zero
    always_comb begin
        reg_rdata_o = '0;
        case (reg_access_i.offset)
            REG_PC:         reg_rdata_o = CTRL_WIDTH'(pc_q);
            REG_DP_ADDR:    reg_rdata_o = dp_addr_q;
            REG_NUM_BLOCKS: reg_rdata_o = CTRL_WIDTH'(num_blocks_q);
            REG_STATUS: begin
                reg_rdata_o[0] = status_i.busy;
                // Upper bit only set for a full 256 block group
                reg_rdata_o[8 +: NUM_BLOCKS_BITS] = status_i.done_count;
            end
            REG_TGROUP:     reg_rdata_o = CTRL_WIDTH'(last_tgroup_q);
            default:        reg_rdata_o = '0;
        endcase
    end

    assign launch_o.valid      = launch_q;
    assign launch_o.pc         = pc_q;
    assign launch_o.dp_addr    = dp_addr_q;
    assign launch_o.num_blocks = num_blocks_q;
    assign launch_o.tgroup_id  = next_tgroup_q;
    assign flush_ic_o          = flush_q;

endmodule

//--- rtl/tblock_dispatcher.sv
/* Thread block dispatcher
   Hands out the blocks of a launch to free warps and counts completions */
`timescale 1ns/1ps

module tblock_dispatcher #(
    parameter int unsigned NUM_BLOCKS_MAX = 256
) (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  ctrl_pkg::launch_cmd_t               launch_i,
    output ctrl_pkg::te_status_t                status_o,
    input  logic                                warp_free_i,
    output logic                                allocate_warp_o,
    output ctrl_pkg::alloc_t                    allocate_o,
    output logic                                tblock_done_ready_o,
    input  logic                                tblock_done_i,
    input  logic [ctrl_pkg::TGROUP_ID_BITS-1:0] tblock_done_id_i
);
    import ctrl_pkg::*;

    logic                       busy_q;
    // Latched launch
    logic [PC_WIDTH-1:0]        pc_q;
    logic [CTRL_WIDTH-1:0]      dp_addr_q;
    logic [NUM_BLOCKS_BITS-1:0] num_blocks_q;
    logic [TGROUP_ID_BITS-1:0]  tgroup_q;
    // Progress counters
    logic [NUM_BLOCKS_BITS-1:0] alloc_cnt_q;
    logic [NUM_BLOCKS_BITS-1:0] done_cnt_q;
    logic [NUM_BLOCKS_BITS-1:0] alloc_cnt_d;
    logic [NUM_BLOCKS_BITS-1:0] done_cnt_d;

    logic                       accept;
    logic                       done_fire;

    // No launch taken while one is running
    assign accept = launch_i.valid && !busy_q;

    // One block per cycle while warps are free
    assign allocate_warp_o = busy_q && (alloc_cnt_q < num_blocks_q) && warp_free_i;

    assign tblock_done_ready_o = busy_q;
    // Only completions of the running group count
    assign done_fire = tblock_done_i && tblock_done_ready_o
                       && (tblock_done_id_i == tgroup_q) && (done_cnt_q < num_blocks_q);

    assign alloc_cnt_d = alloc_cnt_q + NUM_BLOCKS_BITS'(allocate_warp_o);
    assign done_cnt_d  = done_cnt_q + NUM_BLOCKS_BITS'(done_fire);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q      <= 1'b0;
            alloc_cnt_q <= '0;
            done_cnt_q  <= '0;
        end else if (accept) begin
            busy_q      <= 1'b1;
            alloc_cnt_q <= '0;
            done_cnt_q  <= '0;
        end else if (busy_q) begin
            alloc_cnt_q <= alloc_cnt_d;
            done_cnt_q  <= done_cnt_d;
            // Finished once every block is out and back
            if (alloc_cnt_d == num_blocks_q && done_cnt_d == num_blocks_q) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Launch payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            pc_q      <= launch_i.pc;
            dp_addr_q <= launch_i.dp_addr;
            tgroup_q  <= launch_i.tgroup_id;
            // Guard against counts above the supported maximum
            if (launch_i.num_blocks > NUM_BLOCKS_MAX) begin
                num_blocks_q <= NUM_BLOCKS_BITS'(NUM_BLOCKS_MAX);
            end else begin
                num_blocks_q <= launch_i.num_blocks;
            end
        end
    end

    assign allocate_o.pc         = pc_q;
    assign allocate_o.dp_addr    = dp_addr_q;
    assign allocate_o.tblock_idx = alloc_cnt_q[TBLOCK_IDX_BITS-1:0];
    assign allocate_o.tgroup_id  = tgroup_q;

    assign status_o.busy       = busy_q;
    assign status_o.done_count = done_cnt_q;

endmodule

//--- rtl/control_domain.sv
/* Control domain top level
   Host bus control, thread engine registers and block dispatcher */
`timescale 1ns/1ps

module control_domain #(
    parameter int unsigned NUM_BLOCKS_MAX = 256
) (
    input  logic                                clk_i,
    input  logic                                reset_i,

    // Host port
    input  ctrl_pkg::axil_req_t                 axil_req_i,
    output ctrl_pkg::axil_rsp_t                 axil_rsp_o,

    // Instruction cache flush toward compute clusters
    output logic                                flush_ic_o,

    // Block allocation
    input  logic                                warp_free_i,
    output logic                                allocate_warp_o,
    output ctrl_pkg::alloc_t                    allocate_o,

    // Block completion
    output logic                                tblock_done_ready_o,
    input  logic                                tblock_done_i,
    input  logic [ctrl_pkg::TGROUP_ID_BITS-1:0] tblock_done_id_i
);
    import ctrl_pkg::*;

    reg_access_t           reg_access;
    logic [CTRL_WIDTH-1:0] reg_rdata;
    launch_cmd_t           launch;
    te_status_t            status;

    // ####################
    // Bus control
    // ####################

    axil_bus_ctrl i_bus_ctrl (
        .clk_i       ( clk_i      ),
        .reset_i     ( reset_i    ),
        .axil_req_i  ( axil_req_i ),
        .axil_rsp_o  ( axil_rsp_o ),
        .reg_access_o( reg_access ),
        .reg_rdata_i ( reg_rdata  )
    );

    // ####################
    // Thread engine
    // ####################

    te_reg_file #(
        .NUM_BLOCKS_MAX( NUM_BLOCKS_MAX )
    ) i_te_reg_file (
        .clk_i       ( clk_i      ),
        .reset_i     ( reset_i    ),
        .reg_access_i( reg_access ),
        .reg_rdata_o ( reg_rdata  ),
        .status_i    ( status     ),
        .launch_o    ( launch     ),
        .flush_ic_o  ( flush_ic_o )
    );

    tblock_dispatcher #(
        .NUM_BLOCKS_MAX( NUM_BLOCKS_MAX )
    ) i_dispatcher (
        .clk_i              ( clk_i               ),
        .reset_i            ( reset_i             ),
        .launch_i           ( launch              ),
        .status_o           ( status              ),
        .warp_free_i        ( warp_free_i         ),
        .allocate_warp_o    ( allocate_warp_o     ),
        .allocate_o         ( allocate_o          ),
        .tblock_done_ready_o( tblock_done_ready_o ),
        .tblock_done_i      ( tblock_done_i       ),
        .tblock_done_id_i   ( tblock_done_id_i    )
    );

endmodule

//--- verif/control_domain_assertions.sv
/* Control domain protocol assertions
   Bus response hold, allocation order and flush pulse width */
`timescale 1ns/1ps

module control_domain_assertions (
    input logic                clk_i,
    input logic                reset_i,
    input ctrl_pkg::axil_req_t axil_req_i,
    input ctrl_pkg::axil_rsp_t axil_rsp_o,
    input logic                allocate_warp_o,
    input ctrl_pkg::alloc_t    allocate_o,
    input logic                flush_ic_o
);
    int fail_count = 0;

    // Responses stay up and steady until the host takes them
    bvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped before bready");
        end

    rvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        axil_rsp_o.rvalid && !axil_req_i.rready
        |=> axil_rsp_o.rvalid && $stable(axil_rsp_o.rdata))
        else begin
            fail_count++;
            $error("rvalid or rdata changed before rready");
        end

    // Block index steps by one after every allocation
    alloc_in_order: assert property (@(posedge clk_i) disable iff (reset_i)
        allocate_warp_o
        |=> allocate_o.tblock_idx == $past(allocate_o.tblock_idx) + 1'b1)
        else begin
            fail_count++;
            $error("block index did not advance after an allocation");
        end

    flush_single: assert property (@(posedge clk_i) disable iff (reset_i)
        flush_ic_o |=> !flush_ic_o)
        else begin
            fail_count++;
            $error("flush pulse longer than one cycle");
        end

endmodule

bind control_domain control_domain_assertions i_assertions (
    .clk_i          ( clk_i           ),
    .reset_i        ( reset_i         ),
    .axil_req_i     ( axil_req_i      ),
    .axil_rsp_o     ( axil_rsp_o      ),
    .allocate_warp_o( allocate_warp_o ),
    .allocate_o     ( allocate_o      ),
    .flush_ic_o     ( flush_ic_o      )
);

//--- verif/control_domain_tb.sv
/* Control domain testbench
   Host register sequence from a table, compute cluster model and checks */
`timescale 1ns/1ps

module control_domain_tb;
    import ctrl_pkg::*;

    localparam int unsigned NUM_BLOCKS_MAX = 256;
    localparam int unsigned TIMEOUT_CYCLES = 50;
    localparam int unsigned MAX_POLLS      = 100;
    // Launch payload the table leaves in the registers
    localparam logic [PC_WIDTH-1:0]   EXP_PC = 16'h1256;
    localparam logic [CTRL_WIDTH-1:0] EXP_DP = 32'hAB00_2000;

    typedef enum {OP_WR, OP_RD, OP_WAIT, OP_CHK} op_e;

    // One table row, data carries the group id for OP_WAIT
    typedef struct {
        op_e                   op;
        string                 name;
        logic [ADDR_WIDTH-1:0] addr;
        logic [CTRL_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic [CTRL_WIDTH-1:0] exp_data;
        axil_resp_e            exp_resp;
    } row_t;

    logic                      clk;
    logic                      reset;
    axil_req_t                 axil_req;
    axil_rsp_t                 axil_rsp;
    logic                      flush_ic;
    logic                      warp_free;
    logic                      allocate_warp;
    alloc_t                    allocate;
    logic                      tblock_done_ready;
    logic                      tblock_done;
    logic [TGROUP_ID_BITS-1:0] tblock_done_id;

    row_t                      rows[$];
    // Cluster model state
    alloc_t                    alloc_log[$];
    logic [TGROUP_ID_BITS-1:0] pend_id[$];
    int                        pend_due[$];
    int                        cycle     = 0;
    int                        returned  = 0;
    int                        flushes   = 0;
    int                        checks    = 0;
    int                        errors    = 0;
    int                        afails    = 0;
    bit                        timed_out = 1'b0;
    integer                    seed      = 32'ha58b_2d33;

    control_domain #(
        .NUM_BLOCKS_MAX( NUM_BLOCKS_MAX )
    ) control_domain_i (
        .clk_i              ( clk               ),
        .reset_i            ( reset             ),
        .axil_req_i         ( axil_req          ),
        .axil_rsp_o         ( axil_rsp          ),
        .flush_ic_o         ( flush_ic          ),
        .warp_free_i        ( warp_free         ),
        .allocate_warp_o    ( allocate_warp     ),
        .allocate_o         ( allocate          ),
        .tblock_done_ready_o( tblock_done_ready ),
        .tblock_done_i      ( tblock_done       ),
        .tblock_done_id_i   ( tblock_done_id    )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ####################
    // Compute cluster model
    // ####################

    // Log allocations, retire accepted completions, count flush pulses
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!reset && allocate_warp) begin
            alloc_log.push_back(allocate);
            pend_id.push_back(allocate.tgroup_id);
            pend_due.push_back(cycle + 1 + ($random(seed) & 3));
        end
        if (tblock_done && tblock_done_ready) begin
            void'(pend_id.pop_front());
            void'(pend_due.pop_front());
            returned = returned + 1;
        end
        if (flush_ic) begin
            flushes = flushes + 1;
        end
    end

    // Warps free about three cycles in four
    always @(negedge clk) begin
        warp_free = ($random(seed) & 3) != 0;
        if (pend_id.size() > 0 && pend_due[0] <= cycle) begin
            tblock_done    = 1'b1;
            tblock_done_id = pend_id[0];
        end else begin
            tblock_done    = 1'b0;
            tblock_done_id = '0;
        end
    end

    // ####################
    // Host tasks
    // ####################

    task automatic check(input string name, input logic [CTRL_WIDTH-1:0] exp,
                         input logic [CTRL_WIDTH-1:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error %s: expected 0x%h, actual 0x%h", name, exp, got);
        end
    endtask

    // AW and W together, called and left on a falling edge
    task automatic bus_write(input logic [ADDR_WIDTH-1:0] addr,
                             input logic [CTRL_WIDTH-1:0] data,
                             input logic [STRB_WIDTH-1:0] strb,
                             output axil_resp_e resp);
        int n;
        n = 0;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        axil_req.bready  = 1'b1;
        @(posedge clk);
        while (!(axil_rsp.awready && axil_rsp.wready) && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (!(axil_rsp.awready && axil_rsp.wready)) begin
            $display("timeout: write to 0x%h was never accepted", addr);
            timed_out = 1'b1;
        end
        @(negedge clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        n = 0;
        @(posedge clk);
        while (!axil_rsp.bvalid && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (!axil_rsp.bvalid) begin
            $display("timeout: no write response for 0x%h", addr);
            timed_out = 1'b1;
        end
        resp = axil_rsp.bresp;
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic bus_read(input logic [ADDR_WIDTH-1:0] addr,
                            output logic [CTRL_WIDTH-1:0] rdata,
                            output axil_resp_e resp);
        int n;
        n = 0;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        axil_req.rready  = 1'b1;
        @(posedge clk);
        while (!axil_rsp.arready && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (!axil_rsp.arready) begin
            $display("timeout: read of 0x%h was never accepted", addr);
            timed_out = 1'b1;
        end
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        n = 0;
        @(posedge clk);
        while (!axil_rsp.rvalid && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (!axil_rsp.rvalid) begin
            $display("timeout: no read data for 0x%h", addr);
            timed_out = 1'b1;
        end
        rdata = axil_rsp.rdata;
        resp  = axil_rsp.rresp;
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    // Poll STATUS until idle, then check the logged allocations
    task automatic wait_launch(input string name, input logic [TGROUP_ID_BITS-1:0] gid,
                               input int unsigned num);
        axil_resp_e            resp;
        logic [CTRL_WIDTH-1:0] status;
        int                    polls;
        polls  = 0;
        status = 32'h1;
        while (status[0] && polls < MAX_POLLS && !timed_out) begin
            bus_read(TE_BASE | ADDR_WIDTH'(REG_STATUS), status, resp);
            polls++;
        end
        if (!timed_out && status[0]) begin
            $display("timeout: thread engine still busy after %0d status polls", polls);
            timed_out = 1'b1;
        end
        // Not busy means every completion is back
        check({name, " returned"}, num, returned);
        check({name, " count"}, num, alloc_log.size());
        foreach (alloc_log[i]) begin
            check({name, " idx"}, i, alloc_log[i].tblock_idx);
            check({name, " pc"}, EXP_PC, alloc_log[i].pc);
            check({name, " dp"}, EXP_DP, alloc_log[i].dp_addr);
            check({name, " group"}, gid, alloc_log[i].tgroup_id);
        end
        alloc_log.delete();
        returned = 0;
    endtask

    task automatic apply_row(input row_t r);
        axil_resp_e            resp;
        logic [CTRL_WIDTH-1:0] rdata;
        case (r.op)
            OP_WR: begin
                bus_write(r.addr, r.data, r.strb, resp);
                check({r.name, " resp"}, r.exp_resp, resp);
            end
            OP_RD: begin
                bus_read(r.addr, rdata, resp);
                check(r.name, r.exp_data, rdata);
                check({r.name, " resp"}, r.exp_resp, resp);
            end
            OP_WAIT: wait_launch(r.name, r.data[TGROUP_ID_BITS-1:0], r.exp_data);
            OP_CHK: begin
                // Flush pulses so far, and nothing allocated since the last launch
                check({r.name, " flushes"}, r.exp_data, flushes);
                check({r.name, " allocs"}, 0, alloc_log.size());
            end
            default: ;
        endcase
    endtask

    task automatic add_row(input op_e op, input string name,
                           input logic [ADDR_WIDTH-1:0] addr,
                           input logic [CTRL_WIDTH-1:0] data,
                           input logic [STRB_WIDTH-1:0] strb,
                           input logic [CTRL_WIDTH-1:0] exp_data,
                           input axil_resp_e exp_resp);
        rows.push_back('{op, name, addr, data, strb, exp_data, exp_resp});
    endtask

    // ####################
    // Sequence
    // ####################

    initial begin
        reset          = 1'b1;
        axil_req       = '0;
        warp_free      = 1'b0;
        tblock_done    = 1'b0;
        tblock_done_id = '0;

        // Register read back with partial strobes
        add_row(OP_WR, "pc_full",      16'hFF00, 32'hFFFF_1234, 4'hF, 32'h0,         OKAY);
        add_row(OP_WR, "pc_byte0",     16'hFF00, 32'hFFFF_FF56, 4'h1, 32'h0,         OKAY);
        add_row(OP_RD, "pc_rd",        16'hFF00, 32'h0,         4'h0, 32'h0000_1256, OKAY);
        add_row(OP_WR, "dp_full",      16'hFF04, 32'h1000_2000, 4'hF, 32'h0,         OKAY);
        add_row(OP_WR, "dp_byte3",     16'hFF04, 32'hAB00_0000, 4'h8, 32'h0,         OKAY);
        add_row(OP_RD, "dp_rd",        16'hFF04, 32'h0,         4'h0, 32'hAB00_2000, OKAY);
        // Above the maximum, clamped to 256
        add_row(OP_WR, "nb_big",       16'hFF08, 32'h0000_0200, 4'hF, 32'h0,         OKAY);
        add_row(OP_RD, "nb_clamp_rd",  16'hFF08, 32'h0,         4'h0, 32'h0000_0100, OKAY);
        add_row(OP_WR, "nb_low",       16'hFF08, 32'hFFFF_0008, 4'h3, 32'h0,         OKAY);
        add_row(OP_RD, "nb_rd",        16'hFF08, 32'h0,         4'h0, 32'h0000_0008, OKAY);
        // Error responder and unknown window offset
        add_row(OP_WR, "err_wr",       16'h1000, 32'h1234_5678, 4'hF, 32'h0,         SLVERR);
        add_row(OP_RD, "err_rd",       16'h1000, 32'h0,         4'h0, 32'hBADC_AB1E, SLVERR);
        add_row(OP_RD, "err_rd_edge",  16'hFEFC, 32'h0,         4'h0, 32'hBADC_AB1E, SLVERR);
        add_row(OP_RD, "unk_rd",       16'hFF20, 32'h0,         4'h0, 32'h0,         OKAY);
        add_row(OP_WR, "unk_wr",       16'hFF20, 32'h1234_5678, 4'hF, 32'h0,         OKAY);
        add_row(OP_RD, "unk_rd2",      16'hFF20, 32'h0,         4'h0, 32'h0,         OKAY);
        // First launch, group 0
        add_row(OP_WR, "start0",       16'hFF0C, 32'h1,         4'hF, 32'h0,         OKAY);
        add_row(OP_WAIT, "launch0",    16'h0,    32'h0,         4'h0, 32'd8,         OKAY);
        add_row(OP_RD, "tgroup0_rd",   16'hFF14, 32'h0,         4'h0, 32'h0,         OKAY);
        add_row(OP_RD, "status0_rd",   16'hFF10, 32'h0,         4'h0, 32'h0000_0800, OKAY);
        // Second launch plus a start while busy
        add_row(OP_WR, "start1",       16'hFF0C, 32'h1,         4'hF, 32'h0,         OKAY);
        add_row(OP_WR, "start_busy",   16'hFF0C, 32'h1,         4'hF, 32'h0,         OKAY);
        add_row(OP_WAIT, "launch1",    16'h0,    32'h1,         4'h0, 32'd8,         OKAY);
        add_row(OP_RD, "tgroup1_rd",   16'hFF14, 32'h0,         4'h0, 32'h1,         OKAY);
        add_row(OP_RD, "status1_rd",   16'hFF10, 32'h0,         4'h0, 32'h0000_0800, OKAY);
        // Cache flush only
        add_row(OP_WR, "flush",        16'hFF0C, 32'h2,         4'hF, 32'h0,         OKAY);
        add_row(OP_RD, "tgroup2_rd",   16'hFF14, 32'h0,         4'h0, 32'h1,         OKAY);
        add_row(OP_RD, "status2_rd",   16'hFF10, 32'h0,         4'h0, 32'h0000_0800, OKAY);
        add_row(OP_CHK, "flush_chk",   16'h0,    32'h0,         4'h0, 32'h1,         OKAY);

        repeat (5) @(negedge clk);
        reset = 1'b0;

        foreach (rows[i]) begin
            if (!timed_out) begin
                apply_row(rows[i]);
            end
        end

        afails = control_domain_i.i_assertions.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d, timeout %0d",
                 checks, errors, afails, timed_out);
        if (errors == 0 && afails == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- src.f
rtl/ctrl_pkg.sv
rtl/axil_bus_ctrl.sv
rtl/te_reg_file.sv
rtl/tblock_dispatcher.sv
rtl/control_domain.sv
verif/control_domain_assertions.sv
verif/control_domain_tb.sv
